//--- Makefile
LOG := sim.log

sim:
	verilator --binary --timing --assert -f files.f --top-module decode_stage_tb -Mdir obj_dir
	./obj_dir/Vdecode_stage_tb | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

//--- files.f
logic/mips_decode_pkg.sv
logic/main_decoder.sv
logic/alu_decoder.sv
logic/register_file.sv
logic/operand_select.sv
logic/decode_stage.sv
verification/decode_stage_tb.sv

//--- logic/alu_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module alu_decoder (
	input  logic [5:0]               opcode,
	input  logic [5:0]               funct,
	output mips_decode_pkg::alu_op_t alu_op
);
	import mips_decode_pkg::*;

	alu_op_t r_type_op;

	// r-type operation straight from funct
	always_comb begin
		case (funct)
			fn_add, fn_addu:   r_type_op = alu_add;
			fn_sub, fn_subu:   r_type_op = alu_sub;
			fn_and:            r_type_op = alu_and;
			fn_or:             r_type_op = alu_or;
			fn_xor:            r_type_op = alu_xor;
			fn_nor:            r_type_op = alu_nor;
			fn_slt:            r_type_op = alu_slt;
			fn_sltu:           r_type_op = alu_sltu;
			fn_sll, fn_sllv:   r_type_op = alu_sll;
			fn_srl, fn_srlv:   r_type_op = alu_srl;
			fn_sra, fn_srav:   r_type_op = alu_sra;
			// jumps, hi/lo moves, mult/div
			default:           r_type_op = alu_none;
		endcase
	end

	always_comb begin
		case (opcode)
			op_r_type:
				alu_op = r_type_op;
			op_addi, op_addiu:
				alu_op = alu_add;
			op_slti:
				alu_op = alu_slt;
			op_sltiu:
				alu_op = alu_sltu;
			op_andi:
				alu_op = alu_and;
			op_ori:
				alu_op = alu_or;
			op_xori:
				alu_op = alu_xor;
			op_lui:
				alu_op = alu_lui;
			// address generation
			op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw:
				alu_op = alu_add;
			// equality compare
			op_beq, op_bne:
				alu_op = alu_sub;
			default:
				alu_op = alu_none;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         instr_valid,
	input  logic [31:0]                  instr,
	input  logic [31:0]                  pc,
	input  mips_decode_pkg::reg_write_t  wb,
	output logic                         ex_valid,
	output mips_decode_pkg::decoded_t    ex
);
	import mips_decode_pkg::*;

	control_t    ctrl;
	logic        reserved;
	alu_op_t     alu_op;
	logic [31:0] rs_value;
	logic [31:0] rt_value;
	logic [31:0] imm_ext;
	logic [4:0]  dest;
	logic [31:0] link_addr;
	decoded_t    ex_next;

	main_decoder u_main_decoder (
		.instr    (instr),
		.ctrl     (ctrl),
		.reserved (reserved)
	);

	alu_decoder u_alu_decoder (
		.opcode (instr[31:26]),
		.funct  (instr[5:0]),
		.alu_op (alu_op)
	);

	register_file u_register_file (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs_addr  (instr[25:21]),
		.rt_addr  (instr[20:16]),
		.wb       (wb),
		.rs_value (rs_value),
		.rt_value (rt_value)
	);

	operand_select u_operand_select (
		.instr     (instr),
		.pc        (pc),
		.ctrl      (ctrl),
		.imm_ext   (imm_ext),
		.dest      (dest),
		.link_addr (link_addr)
	);

	always_comb begin
		ex_next.ctrl      = ctrl;
		ex_next.alu_op    = alu_op;
		ex_next.rs_value  = rs_value;
		ex_next.rt_value  = rt_value;
		ex_next.imm_ext   = imm_ext;
		ex_next.shamt     = instr[10:6];
		ex_next.dest      = dest;
		ex_next.link_addr = link_addr;
		ex_next.reserved  = reserved;
		ex_next.pc        = pc;
	end

	// stage register toward execute, bundle holds while idle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
			ex       <= '0;
		end else begin
			ex_valid <= instr_valid;
			if (instr_valid)
				ex <= ex_next;
		end
	end

endmodule

`default_nettype wire

//--- logic/main_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module main_decoder (
	input  logic [31:0]                instr,
	output mips_decode_pkg::control_t  ctrl,
	output logic                       reserved
);
	import mips_decode_pkg::*;

	logic [5:0] opcode;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign funct  = instr[5:0];

	// ctrl stays zero on every reserved path
	always_comb begin
		ctrl     = '0;
		reserved = 1'b0;
		case (opcode)
			op_r_type: begin
				case (funct)
					fn_mthi, fn_mtlo: begin
						ctrl.hilo_read  = 1'b1;
						ctrl.hilo_write = 1'b1;
					end
					fn_mfhi, fn_mflo: begin
						ctrl.reg_write = 1'b1;
						ctrl.reg_dst   = dst_rd;
						ctrl.hilo_read = 1'b1;
					end
					fn_mult, fn_multu, fn_div, fn_divu: begin
						ctrl.reg_write  = 1'b1;
						ctrl.reg_dst    = dst_rd;
						ctrl.hilo_write = 1'b1;
					end
					fn_jr: begin
						// rt, rd and shamt must all be zero
						if (instr[20:6] != 15'b0)
							reserved = 1'b1;
						else
							ctrl.jump = 1'b1;
					end
					fn_jalr: begin
						if (rt != 5'b0 || instr[10:6] != 5'b0) begin
							reserved = 1'b1;
						end else begin
							ctrl.reg_write  = 1'b1;
							ctrl.reg_dst    = dst_rd;
							ctrl.alu_src_pc = 1'b1;
							ctrl.jump       = 1'b1;
						end
					end
					default: begin
						ctrl.reg_write = 1'b1;
						ctrl.reg_dst   = dst_rd;
					end
				endcase
			end
			op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			op_lui: begin
				ctrl.reg_write     = 1'b1;
				ctrl.alu_src_imm   = 1'b1;
				ctrl.unsign_extend = 1'b1;
			end
			op_lb, op_lh, op_lw, op_lbu, op_lhu: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.write_src   = src_mem;
			end
			op_sb, op_sh, op_sw:
				ctrl.alu_src_imm = 1'b1;
			op_beq, op_bne:
				ctrl.branch = 1'b1;
			op_blez, op_bgtz: begin
				if (rt != 5'b0)
					reserved = 1'b1;
				else
					ctrl.branch = 1'b1;
			end
			op_regimm: begin
				case (rt)
					rt_bltzal, rt_bgezal: begin
						ctrl.reg_write  = 1'b1;
						ctrl.reg_dst    = dst_ra;
						ctrl.alu_src_pc = 1'b1;
						ctrl.branch     = 1'b1;
					end
					rt_bltz, rt_bgez:
						ctrl.branch = 1'b1;
					default:
						reserved = 1'b1;
				endcase
			end
			op_j:
				ctrl.jump = 1'b1;
			op_jal: begin
				ctrl.reg_write  = 1'b1;
				ctrl.reg_dst    = dst_ra;
				ctrl.alu_src_pc = 1'b1;
				ctrl.jump       = 1'b1;
			end
			op_cop0: begin
				case (rs)
					rs_mfc0: begin
						ctrl.reg_write = 1'b1;
						ctrl.write_src = src_cp0;
						ctrl.cp0_read  = 1'b1;
					end
					rs_mtc0:
						ctrl.cp0_write = 1'b1;
					// eret carries no control of its own here
					rs_eret: ;
					default:
						reserved = 1'b1;
				endcase
			end
			default:
				reserved = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/mips_decode_pkg.sv
`default_nettype none

package mips_decode_pkg;

	// primary opcodes, instr[31:26]
	localparam logic [5:0] op_r_type = 6'b000000;
	localparam logic [5:0] op_regimm = 6'b000001;
	localparam logic [5:0] op_j      = 6'b000010;
	localparam logic [5:0] op_jal    = 6'b000011;
	localparam logic [5:0] op_beq    = 6'b000100;
	localparam logic [5:0] op_bne    = 6'b000101;
	localparam logic [5:0] op_blez   = 6'b000110;
	localparam logic [5:0] op_bgtz   = 6'b000111;
	localparam logic [5:0] op_addi   = 6'b001000;
	localparam logic [5:0] op_addiu  = 6'b001001;
	localparam logic [5:0] op_slti   = 6'b001010;
	localparam logic [5:0] op_sltiu  = 6'b001011;
	localparam logic [5:0] op_andi   = 6'b001100;
	localparam logic [5:0] op_ori    = 6'b001101;
	localparam logic [5:0] op_xori   = 6'b001110;
	localparam logic [5:0] op_lui    = 6'b001111;
	localparam logic [5:0] op_cop0   = 6'b010000;
	localparam logic [5:0] op_lb     = 6'b100000;
	localparam logic [5:0] op_lh     = 6'b100001;
	localparam logic [5:0] op_lw     = 6'b100011;
	localparam logic [5:0] op_lbu    = 6'b100100;
	localparam logic [5:0] op_lhu    = 6'b100101;
	localparam logic [5:0] op_sb     = 6'b101000;
	localparam logic [5:0] op_sh     = 6'b101001;
	localparam logic [5:0] op_sw     = 6'b101011;

	// r-type funct, instr[5:0]
	localparam logic [5:0] fn_sll   = 6'b000000;
	localparam logic [5:0] fn_srl   = 6'b000010;
	localparam logic [5:0] fn_sra   = 6'b000011;
	localparam logic [5:0] fn_sllv  = 6'b000100;
	localparam logic [5:0] fn_srlv  = 6'b000110;
	localparam logic [5:0] fn_srav  = 6'b000111;
	localparam logic [5:0] fn_jr    = 6'b001000;
	localparam logic [5:0] fn_jalr  = 6'b001001;
	localparam logic [5:0] fn_mfhi  = 6'b010000;
	localparam logic [5:0] fn_mthi  = 6'b010001;
	localparam logic [5:0] fn_mflo  = 6'b010010;
	localparam logic [5:0] fn_mtlo  = 6'b010011;
	localparam logic [5:0] fn_mult  = 6'b011000;
	localparam logic [5:0] fn_multu = 6'b011001;
	localparam logic [5:0] fn_div   = 6'b011010;
	localparam logic [5:0] fn_divu  = 6'b011011;
	localparam logic [5:0] fn_add   = 6'b100000;
	localparam logic [5:0] fn_addu  = 6'b100001;
	localparam logic [5:0] fn_sub   = 6'b100010;
	localparam logic [5:0] fn_subu  = 6'b100011;
	localparam logic [5:0] fn_and   = 6'b100100;
	localparam logic [5:0] fn_or    = 6'b100101;
	localparam logic [5:0] fn_xor   = 6'b100110;
	localparam logic [5:0] fn_nor   = 6'b100111;
	localparam logic [5:0] fn_slt   = 6'b101010;
	localparam logic [5:0] fn_sltu  = 6'b101011;

	// regimm branches, selected by rt
	localparam logic [4:0] rt_bltz   = 5'b00000;
	localparam logic [4:0] rt_bgez   = 5'b00001;
	localparam logic [4:0] rt_bltzal = 5'b10000;
	localparam logic [4:0] rt_bgezal = 5'b10001;

	// cop0 forms, selected by rs
	localparam logic [4:0] rs_mfc0 = 5'b00000;
	localparam logic [4:0] rs_mtc0 = 5'b00100;
	localparam logic [4:0] rs_eret = 5'b10000;

	typedef enum logic [1:0] {
		dst_rt = 2'b00,
		dst_rd = 2'b01,
		dst_ra = 2'b10
	} reg_dst_t;

	typedef enum logic [1:0] {
		src_alu = 2'b00,
		src_mem = 2'b01,
		src_cp0 = 2'b10
	} write_src_t;

	// field order follows the 14-bit control vector, reg_write is the msb
	typedef struct packed {
		logic       reg_write;
		reg_dst_t   reg_dst;
		logic       alu_src_pc;
		logic       alu_src_imm;
		write_src_t write_src;
		logic       hilo_read;
		logic       hilo_write;
		logic       branch;
		logic       unsign_extend;
		logic       jump;
		logic       cp0_write;
		logic       cp0_read;
	} control_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt,
		alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui, alu_none
	} alu_op_t;

	// writeback port into the register file
	typedef struct packed {
		logic        en;
		logic [4:0]  addr;
		logic [31:0] data;
	} reg_write_t;

	// bundle handed to execute
	typedef struct packed {
		control_t    ctrl;
		alu_op_t     alu_op;
		logic [31:0] rs_value;
		logic [31:0] rt_value;
		logic [31:0] imm_ext;
		logic [4:0]  shamt;
		logic [4:0]  dest;
		logic [31:0] link_addr;
		logic        reserved;
		logic [31:0] pc;
	} decoded_t;

endpackage

`default_nettype wire

//--- logic/operand_select.sv
`timescale 1ns/100ps
`default_nettype none

module operand_select (
	input  logic [31:0]               instr,
	input  logic [31:0]               pc,
	input  mips_decode_pkg::control_t ctrl,
	output logic [31:0]               imm_ext,
	output logic [4:0]                dest,
	output logic [31:0]               link_addr
);
	import mips_decode_pkg::*;

	logic [5:0]  opcode;
	logic [15:0] imm;
	logic        zero_ext;

	assign opcode = instr[31:26];
	assign imm    = instr[15:0];

	// logical immediates zero-extend as well as lui
	assign zero_ext = ctrl.unsign_extend || opcode == op_andi ||
		opcode == op_ori || opcode == op_xori;

	assign imm_ext = zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};

	always_comb begin
		case (ctrl.reg_dst)
			dst_rd:  dest = instr[15:11];
			dst_ra:  dest = 5'd31;
			default: dest = instr[20:16];
		endcase
	end

	// return address skips the delay slot
	assign link_addr = pc + 32'd8;

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic [4:0]                    rs_addr,
	input  logic [4:0]                    rt_addr,
	input  mips_decode_pkg::reg_write_t   wb,
	output logic [31:0]                   rs_value,
	output logic [31:0]                   rt_value
);
	import mips_decode_pkg::*;

	// register zero has no storage
	logic [31:0] regs [1:31];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wb.en && wb.addr != 5'd0) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// same-cycle write is forwarded to the read ports
	always_comb begin
		if (rs_addr == 5'd0)
			rs_value = '0;
		else if (wb.en && wb.addr == rs_addr)
			rs_value = wb.data;
		else
			rs_value = regs[rs_addr];

		if (rt_addr == 5'd0)
			rt_value = '0;
		else if (wb.en && wb.addr == rt_addr)
			rt_value = wb.data;
		else
			rt_value = regs[rt_addr];
	end

endmodule

`default_nettype wire

//--- verification/decode_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage_tb;
	import mips_decode_pkg::*;

	logic        clk;
	logic        arst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] pc;
	reg_write_t  wb;
	logic        ex_valid;
	decoded_t    ex;

	// reference state and results still owed by the DUT
	logic [31:0] shadow [32];
	decoded_t    exp_q [$];
	logic [31:0] rng = 32'd57;
	int          run_len = 0;
	int          errors = 0;
	int          pass_count = 0;
	int          fail_count = 0;

	decode_stage DUT (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.wb          (wb),
		.ex_valid    (ex_valid),
		.ex          (ex)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// xorshift32
	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [31:0] random_pc();
		return next_random() & 32'hffff_fffc;
	endfunction

	function automatic logic [31:0] r_instr(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {op_r_type, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] i_instr(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// register zero, then same-cycle write, then stored value
	function automatic logic [31:0] read_model(input logic [4:0] addr, input reg_write_t wr);
		if (addr == 5'd0)
			return 32'd0;
		if (wr.en && wr.addr == addr)
			return wr.data;
		return shadow[addr];
	endfunction

	function automatic decoded_t expect_decode(input logic [31:0] w, input logic [31:0] p,
		input reg_write_t wr);
		decoded_t    d;
		logic [13:0] c;
		logic        rsv;
		alu_op_t     alu;
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  rt;
		op = w[31:26];
		fn = w[5:0];
		rt = w[20:16];
		d = '0;
		rsv = 1'b0;
		alu = alu_none;
		// control columns in order rw dst pc imm src hr hw br ue j c0w c0r
		case (op)
			op_r_type: begin
				case (fn)
					fn_mthi, fn_mtlo:                   c = 14'b0_00_0_0_00_1_1_0_0_0_0_0;
					fn_mfhi, fn_mflo:                   c = 14'b1_01_0_0_00_1_0_0_0_0_0_0;
					fn_mult, fn_multu, fn_div, fn_divu: c = 14'b1_01_0_0_00_0_1_0_0_0_0_0;
					fn_jr: begin
						c = 14'b0_00_0_0_00_0_0_0_0_1_0_0;
						rsv = (w[20:6] != 15'd0);
					end
					fn_jalr: begin
						c = 14'b1_01_1_0_00_0_0_0_0_1_0_0;
						rsv = (rt != 5'd0 || w[10:6] != 5'd0);
					end
					default:                            c = 14'b1_01_0_0_00_0_0_0_0_0_0_0;
				endcase
				case (fn)
					fn_add, fn_addu: alu = alu_add;
					fn_sub, fn_subu: alu = alu_sub;
					fn_and:          alu = alu_and;
					fn_or:           alu = alu_or;
					fn_xor:          alu = alu_xor;
					fn_nor:          alu = alu_nor;
					fn_slt:          alu = alu_slt;
					fn_sltu:         alu = alu_sltu;
					fn_sll, fn_sllv: alu = alu_sll;
					fn_srl, fn_srlv: alu = alu_srl;
					fn_sra, fn_srav: alu = alu_sra;
					default:         alu = alu_none;
				endcase
			end
			op_addi, op_addiu: begin
				c = 14'b1_00_0_1_00_0_0_0_0_0_0_0;
				alu = alu_add;
			end
			op_slti: begin
				c = 14'b1_00_0_1_00_0_0_0_0_0_0_0;
				alu = alu_slt;
			end
			op_sltiu: begin
				c = 14'b1_00_0_1_00_0_0_0_0_0_0_0;
				alu = alu_sltu;
			end
			op_andi: begin
				c = 14'b1_00_0_1_00_0_0_0_0_0_0_0;
				alu = alu_and;
			end
			op_ori: begin
				c = 14'b1_00_0_1_00_0_0_0_0_0_0_0;
				alu = alu_or;
			end
			op_xori: begin
				c = 14'b1_00_0_1_00_0_0_0_0_0_0_0;
				alu = alu_xor;
			end
			op_lui: begin
				c = 14'b1_00_0_1_00_0_0_0_1_0_0_0;
				alu = alu_lui;
			end
			op_lb, op_lh, op_lw, op_lbu, op_lhu: begin
				c = 14'b1_00_0_1_01_0_0_0_0_0_0_0;
				alu = alu_add;
			end
			op_sb, op_sh, op_sw: begin
				c = 14'b0_00_0_1_00_0_0_0_0_0_0_0;
				alu = alu_add;
			end
			op_beq, op_bne: begin
				c = 14'b0_00_0_0_00_0_0_1_0_0_0_0;
				alu = alu_sub;
			end
			op_blez, op_bgtz: begin
				c = 14'b0_00_0_0_00_0_0_1_0_0_0_0;
				rsv = (rt != 5'd0);
			end
			op_regimm: begin
				case (rt)
					rt_bltz, rt_bgez:     c = 14'b0_00_0_0_00_0_0_1_0_0_0_0;
					rt_bltzal, rt_bgezal: c = 14'b1_10_1_0_00_0_0_1_0_0_0_0;
					default:              rsv = 1'b1;
				endcase
			end
			op_j:   c = 14'b0_00_0_0_00_0_0_0_0_1_0_0;
			op_jal: c = 14'b1_10_1_0_00_0_0_0_0_1_0_0;
			op_cop0: begin
				case (w[25:21])
					rs_mfc0: c = 14'b1_00_0_0_10_0_0_0_0_0_0_1;
					rs_mtc0: c = 14'b0_00_0_0_00_0_0_0_0_0_1_0;
					rs_eret: c = 14'b0;
					default: rsv = 1'b1;
				endcase
			end
			default: rsv = 1'b1;
		endcase
		if (rsv)
			c = 14'b0;
		d.ctrl = c;
		d.alu_op = alu;
		d.rs_value = read_model(w[25:21], wr);
		d.rt_value = read_model(rt, wr);
		// lui and the logical immediates zero-extend
		if (op == op_lui || op == op_andi || op == op_ori || op == op_xori)
			d.imm_ext = {16'd0, w[15:0]};
		else
			d.imm_ext = {{16{w[15]}}, w[15:0]};
		d.shamt = w[10:6];
		case (d.ctrl.reg_dst)
			dst_rd:  d.dest = w[15:11];
			dst_ra:  d.dest = 5'd31;
			default: d.dest = rt;
		endcase
		d.link_addr = p + 32'd8;
		d.reserved = rsv;
		d.pc = p;
		return d;
	endfunction

	// drives one rising edge and queues the expected result when valid
	task automatic drive_cycle(input logic v, input logic [31:0] w, input logic [31:0] p,
		input reg_write_t wr);
		@(posedge clk);
		instr_valid <= v;
		instr <= w;
		pc <= p;
		wb <= wr;
		if (v)
			exp_q.push_back(expect_decode(w, p, wr));
		if (wr.en && wr.addr != 5'd0)
			shadow[wr.addr] = wr.data;
	endtask

	task automatic issue(input logic [31:0] w, input logic [31:0] p);
		drive_cycle(1'b1, w, p, '0);
	endtask

	task automatic go_idle();
		drive_cycle(1'b0, 32'd0, 32'd0, '0);
	endtask

	task automatic drain(input string what, output bit ok);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 64) begin
			@(posedge clk);
			n++;
		end
		ok = (exp_q.size() == 0);
		if (!ok)
			$display("timeout: %s still waiting on %0d ex_valid strobes", what, exp_q.size());
	endtask

	task automatic report(input string name, input bit ok, input int e0);
		if (!ok) begin
			$display("test %s: timed out", name);
			fail_count++;
		end else if (errors != e0) begin
			$display("test %s: %0d mismatches", name, errors - e0);
			fail_count++;
		end else begin
			$display("test %s: ok", name);
			pass_count++;
		end
	endtask

	task automatic register_readback(output bit ok);
		int          e0;
		reg_write_t  wr;
		logic [31:0] r;
		e0 = errors;
		@(negedge clk);
		assert (ex_valid == 1'b0 && ex == '0) else begin
			$display("FAILED at %0t: ex_valid or ex not cleared by reset", $time);
			errors++;
		end
		// register zero gets a write too
		for (int a = 0; a < 32; a++) begin
			wr.en = 1'b1;
			wr.addr = a[4:0];
			wr.data = next_random();
			drive_cycle(1'b0, 32'd0, 32'd0, wr);
		end
		for (int a = 0; a < 32; a++) begin
			r = next_random();
			issue(r_instr(a[4:0], 5'd31 - a[4:0], r[4:0], 5'd0, fn_add), random_pc());
		end
		wr.addr = 5'd9;
		wr.data = next_random();
		drive_cycle(1'b1, r_instr(5'd9, 5'd9, 5'd1, 5'd0, fn_or), random_pc(), wr);
		go_idle();
		drain("register readback", ok);
		report("registers", ok, e0);
	endtask

	task automatic rtype_burst(output bit ok);
		int          e0;
		logic [5:0]  fns [10];
		logic [31:0] r;
		e0 = errors;
		fns = '{fn_add, fn_sub, fn_and, fn_or, fn_slt, fn_sll, fn_mfhi, fn_mtlo, fn_mult,
			fn_divu};
		for (int i = 0; i < 10; i++) begin
			r = next_random();
			issue(r_instr(r[25:21], r[20:16], r[15:11], r[10:6], fns[i]), random_pc());
		end
		go_idle();
		drain("r-type burst", ok);
		assert (!ok || run_len == 10) else begin
			$display("FAILED at %0t: ex_valid burst of %0d cycles, expected 10", $time, run_len);
			errors++;
		end
		report("r-type", ok, e0);
	endtask

	task automatic immediate_forms(output bit ok);
		int          e0;
		logic [5:0]  ops [6];
		logic [31:0] r;
		e0 = errors;
		ops = '{op_addi, op_slti, op_andi, op_ori, op_xori, op_lui};
		// each opcode with bit 15 clear, then set
		for (int i = 0; i < 12; i++) begin
			r = next_random();
			r[15] = i[0];
			issue(i_instr(ops[i / 2], r[25:21], r[20:16], r[15:0]), random_pc());
		end
		go_idle();
		drain("immediates", ok);
		report("immediates", ok, e0);
	endtask

	task automatic load_store_forms(output bit ok);
		int          e0;
		logic [5:0]  ops [8];
		logic [31:0] r;
		e0 = errors;
		ops = '{op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw};
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			issue(i_instr(ops[i], r[25:21], r[20:16], r[15:0]), random_pc());
		end
		go_idle();
		drain("loads and stores", ok);
		report("memory", ok, e0);
	endtask

	task automatic branch_and_jump(output bit ok);
		int          e0;
		logic [31:0] r;
		e0 = errors;
		r = next_random();
		issue(i_instr(op_beq, r[25:21], r[20:16], r[15:0]), random_pc());
		issue(i_instr(op_bne, r[25:21], r[20:16], r[15:0]), random_pc());
		issue(i_instr(op_blez, r[25:21], 5'd0, r[15:0]), random_pc());
		issue(i_instr(op_bgtz, r[25:21], 5'd0, r[15:0]), random_pc());
		issue(i_instr(op_regimm, r[25:21], rt_bltz, r[15:0]), random_pc());
		issue(i_instr(op_regimm, r[25:21], rt_bgez, r[15:0]), random_pc());
		issue(i_instr(op_regimm, r[25:21], rt_bltzal, r[15:0]), random_pc());
		issue(i_instr(op_regimm, r[25:21], rt_bgezal, r[15:0]), random_pc());
		issue({op_j, r[25:0]}, random_pc());
		issue({op_jal, r[25:0]}, random_pc());
		issue(r_instr(r[25:21], 5'd0, 5'd0, 5'd0, fn_jr), random_pc());
		issue(r_instr(r[25:21], 5'd0, r[15:11], 5'd0, fn_jalr), random_pc());
		go_idle();
		drain("branches and jumps", ok);
		report("control flow", ok, e0);
	endtask

	task automatic reserved_and_cop0(output bit ok);
		int          e0;
		logic [31:0] r;
		e0 = errors;
		r = next_random();
		issue({op_cop0, rs_mfc0, r[20:16], r[15:11], 11'd0}, random_pc());
		issue({op_cop0, rs_mtc0, r[20:16], r[15:11], 11'd0}, random_pc());
		issue({op_cop0, rs_eret, 15'd0, 6'h18}, random_pc());
		// malformed encodings
		issue(r_instr(r[25:21], 5'd0, 5'd3, 5'd0, fn_jr), random_pc());
		issue(i_instr(op_bgtz, r[25:21], 5'd4, r[15:0]), random_pc());
		issue(i_instr(op_regimm, r[25:21], 5'b00101, r[15:0]), random_pc());
		issue({op_cop0, 5'b00001, r[20:0]}, random_pc());
		issue({6'b111111, r[25:0]}, random_pc());
		go_idle();
		drain("cop0 and reserved", ok);
		report("reserved and cop0", ok, e0);
	endtask

	task automatic run_all(output bit ok);
		register_readback(ok);
		if (!ok)
			return;
		rtype_burst(ok);
		if (!ok)
			return;
		immediate_forms(ok);
		if (!ok)
			return;
		load_store_forms(ok);
		if (!ok)
			return;
		branch_and_jump(ok);
		if (!ok)
			return;
		reserved_and_cop0(ok);
	endtask

	// ex is stable at the falling edge
	initial begin
		decoded_t head;
		forever begin
			@(negedge clk);
			if (arst_n && ex_valid) begin
				run_len++;
				if (exp_q.size() == 0) begin
					$display("ex_valid at %0t with no instruction outstanding", $time);
					errors++;
				end else begin
					head = exp_q.pop_front();
					assert (ex == head) else begin
						$display("FAILED at %0t: pc %h got %h expected %h",
							$time, head.pc, ex, head);
						errors++;
					end
					assert (!ex.reserved || ex.ctrl == '0) else begin
						$display("FAILED at %0t: reserved with ctrl %h", $time, ex.ctrl);
						errors++;
					end
				end
			end else begin
				run_len = 0;
			end
		end
	end

	initial begin
		bit ok;
		arst_n = 1'b0;
		instr_valid = 1'b0;
		instr = 32'd0;
		pc = 32'd0;
		wb = '0;
		for (int i = 0; i < 32; i++)
			shadow[i] = 32'd0;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		run_all(ok);
		$display("tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (!ok || fail_count != 0 || errors != 0)
			$display("TESTBENCH FAILED");
		else
			$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire
